// File: rtl/rsc2_engine_cfg.svh
// rsc2 engine configuration
// widths, saturation limits and pipeline latencies of the two-lane core

`ifndef RSC2_ENGINE_CFG_SVH
`define RSC2_ENGINE_CFG_SVH

// ----------------------------------------
// data widths
// ----------------------------------------
`define RSC2_LLR_W        5   // one soft bit
`define RSC2_LLR_MAX      (15) // symmetric limit, -16 never produced
`define RSC2_ADDR_W       8
`define RSC2_DTAG_W       8   // duo-bit tag, multichannel modes
`define RSC2_STATE_W      10  // reliability metric, saturates at all ones
`define RSC2_ERR_W        16  // estimated bit error counter

// ----------------------------------------
// pipeline latencies in clocks
// ----------------------------------------
`define RSC2_BMC_DELAY    1
`define RSC2_RP_DELAY     1

// input beat to output beat
`define RSC2_ENGINE_DELAY (`RSC2_BMC_DELAY + `RSC2_RP_DELAY)

`endif

// File: rtl/rsc2_engine_pkg.sv
// rsc2 engine shared types
// llr, duo-bit, metric and control types used by both lanes

`include "rsc2_engine_cfg.svh"

package rsc2_engine_pkg;

  // ----------------------------------------
  // soft values
  // ----------------------------------------

  // signed llr, two's complement
  typedef logic signed [`RSC2_LLR_W-1 : 0] bit_llr_t;

  // duo-bit llr pair, [0] is bit a and [1] is bit b
  typedef bit_llr_t [1 : 0] llr_pair_t;

  // hard decisions or error flags of one duo-bit
  typedef logic [1 : 0] dbit_t;

  // unsigned reliability metric
  typedef logic [`RSC2_STATE_W-1 : 0] state_t;

  // ----------------------------------------
  // beat side info
  // ----------------------------------------

  typedef logic [`RSC2_ADDR_W-1 : 0] addr_t;
  typedef logic [`RSC2_DTAG_W-1 : 0] dtag_t;
  typedef logic [`RSC2_ERR_W-1 : 0]  err_cnt_t;

  // block framing that rides the control pipe
  typedef struct packed {
    logic sop;
    logic eop;
    logic last;  // last sub-iteration
  } ctrl_t;

endpackage

// File: rtl/rsc2_delay_line.sv
// rsc2 fixed depth delay line
// DEPTH stage register pipe for any packed payload, optional async reset

`timescale 1ns/100ps

module rsc2_delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1,
  parameter bit  RESET_EN  = 1'b0  // set for control payloads only
) (
  input  logic     iclk,
  input  logic     ireset,
  input  payload_t idata,
  output payload_t odata
);

  payload_t pipe [DEPTH];  // [0] is the youngest stage

  generate
    if (RESET_EN) begin : g_rst
      // control stages, nothing stale after reset
      always_ff @(posedge iclk or posedge ireset) begin
        if (ireset) begin
          for (int i = 0; i < DEPTH; i++) begin
            pipe[i] <= '0;
          end
        end
        else begin
          pipe[0] <= idata;
          for (int i = 1; i < DEPTH; i++) begin
            pipe[i] <= pipe[i-1];
          end
        end
      end
    end
    else begin : g_norst
      // plain data stages
      always_ff @(posedge iclk) begin
        pipe[0] <= idata;
        for (int i = 1; i < DEPTH; i++) begin
          pipe[i] <= pipe[i-1];
        end
      end
    end
  endgenerate

  assign odata = pipe[DEPTH-1];  // oldest stage

endmodule

// File: rtl/rsc2_dec_bmc.sv
// rsc2 lane branch unit
// a-priori llr sum, hard decision, error estimate and lane metric, one clock

`timescale 1ns/100ps

`include "rsc2_engine_cfg.svh"

module rsc2_dec_bmc (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      ival,
  input  logic                      ifirst,   // no extrinsic yet
  input  logic                      iswap,    // exchange duo-bit halves
  input  rsc2_engine_pkg::llr_pair_t is_llr,  // channel systematic llr
  input  rsc2_engine_pkg::llr_pair_t ilextr,  // extrinsic from last pass
  output logic                      oval,
  output rsc2_engine_pkg::dbit_t    odat,
  output rsc2_engine_pkg::dbit_t    oderr,
  output rsc2_engine_pkg::state_t   ometric
);

  import rsc2_engine_pkg::*;

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // llr add, clipped to +/- limit
  function automatic bit_llr_t llr_sat_add(input bit_llr_t a, input bit_llr_t b);
    logic signed [`RSC2_LLR_W : 0] full;
    full = a + b;  // one guard bit, cannot wrap
    if (full > `RSC2_LLR_MAX) begin
      return bit_llr_t'(`RSC2_LLR_MAX);
    end
    else if (full < -`RSC2_LLR_MAX) begin
      return bit_llr_t'(-`RSC2_LLR_MAX);
    end
    return full[`RSC2_LLR_W-1 : 0];
  endfunction

  // magnitude of a clipped llr
  function automatic state_t llr_mag(input bit_llr_t a);
    bit_llr_t m;
    m = a[`RSC2_LLR_W-1] ? -a : a;  // -16 never reaches here
    return state_t'(unsigned'(m));
  endfunction

  // ----------------------------------------
  // a-priori sum and decisions
  // ----------------------------------------

  llr_pair_t lextr;   // extrinsic, zeroed on first pass
  llr_pair_t lapri;   // saturated a-priori sum
  dbit_t     hd;      // hard decision
  dbit_t     ch_hd;   // channel only decision
  dbit_t     err;

  assign lextr = ifirst ? '0 : ilextr;

  assign lapri[0] = llr_sat_add(is_llr[0], lextr[0]);
  assign lapri[1] = llr_sat_add(is_llr[1], lextr[1]);

  assign hd    = {lapri[1][`RSC2_LLR_W-1], lapri[0][`RSC2_LLR_W-1]};   // negative -> 1
  assign ch_hd = {is_llr[1][`RSC2_LLR_W-1], is_llr[0][`RSC2_LLR_W-1]};
  assign err   = hd ^ ch_hd;  // extrinsic flipped the channel

  // ----------------------------------------
  // output register
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end
    else begin
      oval <= ival;
    end
  end

  always_ff @(posedge iclk) begin
    if (ival) begin
      odat    <= iswap ? {hd[0], hd[1]}   : hd;
      oderr   <= iswap ? {err[0], err[1]} : err;
      ometric <= llr_mag(lapri[0]) + llr_mag(lapri[1]);
    end
  end

  // registered metric stays inside two clipped magnitudes
  a_metric_range : assert property (@(posedge iclk) disable iff (ireset)
    oval |-> (ometric <= state_t'(2 * `RSC2_LLR_MAX)));

endmodule

// File: rtl/rsc2_dec_state_rp.sv
// rsc2 lane state recursion
// saturating metric accumulate with circular trellis load and even/odd store

`timescale 1ns/100ps

module rsc2_dec_state_rp (
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    ival,
  input  logic                    isop,
  input  logic                    ieop,
  input  logic                    ifirst,       // start from zero state
  input  logic                    ieven,        // selects even/odd state slot
  input  rsc2_engine_pkg::state_t imetric,
  input  rsc2_engine_pkg::state_t istate_even,  // handed over from last pass
  input  rsc2_engine_pkg::state_t istate_odd,
  output logic                    oval,
  output rsc2_engine_pkg::state_t ostate,       // running state
  output rsc2_engine_pkg::state_t ostate_even,  // stored at eop
  output rsc2_engine_pkg::state_t ostate_odd
);

  import rsc2_engine_pkg::*;

  // clip at all ones
  function automatic state_t sat_add(input state_t a, input state_t b);
    logic [$bits(state_t) : 0] full;
    full = {1'b0, a} + {1'b0, b};
    return full[$bits(state_t)] ? '1 : full[$bits(state_t)-1 : 0];
  endfunction

  // ----------------------------------------
  // circular trellis load
  // ----------------------------------------

  state_t state;
  state_t init_state;
  state_t base_state;
  state_t next_state;

  // ifirst and ieven steady over the block
  assign init_state = ifirst ? '0 : (ieven ? istate_even : istate_odd);

  assign base_state = isop ? init_state : state;  // sop restarts the trellis
  assign next_state = sat_add(base_state, imetric);

  // ----------------------------------------
  // recursion and even/odd store
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval        <= 1'b0;
      state       <= '0;
      ostate_even <= '0;
      ostate_odd  <= '0;
    end
    else begin
      oval <= ival;
      if (ival) begin
        state <= next_state;
        // new decode, forget both slots
        if (isop && ifirst) begin
          ostate_even <= '0;
          ostate_odd  <= '0;
        end
        // eop write wins over the clear on one beat blocks
        if (ieop) begin
          if (ieven) begin
            ostate_even <= next_state;
          end
          else begin
            ostate_odd <= next_state;
          end
        end
      end
    end
  end

  assign ostate = state;

  // framing comes from the top control pipe, must ride a valid beat
  a_frame_on_val : assert property (@(posedge iclk) disable iff (ireset)
    (isop || ieop) |-> ival);

endmodule

// File: rtl/rsc2_dec_engine.sv
// rsc2 duo-binary decoder engine, two-lane core
// forward and backward lanes side by side, control pipe, error count, done

`timescale 1ns/100ps

`include "rsc2_engine_cfg.svh"

module rsc2_dec_engine (
  input  logic                       iclk,
  input  logic                       ireset,
  // block level, held for the whole block
  input  logic                       ifirst,
  input  logic                       ilast,
  input  logic                       ieven,
  input  logic                       ibitswap,
  // beat framing
  input  logic                       ival,
  input  logic                       isop,
  input  logic                       ieop,
  // forward lane beat
  input  rsc2_engine_pkg::addr_t     ifaddr,
  input  rsc2_engine_pkg::llr_pair_t ifs_llr,
  input  rsc2_engine_pkg::llr_pair_t if_lextr,
  input  rsc2_engine_pkg::dtag_t     ifs_tag,
  // backward lane beat
  input  rsc2_engine_pkg::addr_t     ibaddr,
  input  rsc2_engine_pkg::llr_pair_t ibs_llr,
  input  rsc2_engine_pkg::llr_pair_t ib_lextr,
  input  rsc2_engine_pkg::dtag_t     ibs_tag,
  // circular trellis states in
  input  rsc2_engine_pkg::state_t    if_state_even,
  input  rsc2_engine_pkg::state_t    if_state_odd,
  input  rsc2_engine_pkg::state_t    ib_state_even,
  input  rsc2_engine_pkg::state_t    ib_state_odd,
  // output beat
  output logic                       oval,
  output logic                       osop,
  output logic                       oeop,
  output rsc2_engine_pkg::addr_t     ofaddr,
  output rsc2_engine_pkg::addr_t     obaddr,
  output rsc2_engine_pkg::dbit_t     ofdat,
  output rsc2_engine_pkg::dbit_t     ofderr,
  output rsc2_engine_pkg::dtag_t     ofdtag,
  output rsc2_engine_pkg::dbit_t     obdat,
  output rsc2_engine_pkg::dbit_t     obderr,
  output rsc2_engine_pkg::dtag_t     obdtag,
  // circular trellis states out
  output rsc2_engine_pkg::state_t    of_state_even,
  output rsc2_engine_pkg::state_t    of_state_odd,
  output rsc2_engine_pkg::state_t    ob_state_even,
  output rsc2_engine_pkg::state_t    ob_state_odd,
  output rsc2_engine_pkg::err_cnt_t  oerr,   // estimated bit errors of the block
  output logic                       odone   // eop of the last sub-iteration
);

  import rsc2_engine_pkg::*;

  typedef struct packed {
    logic  val;
    ctrl_t ctrl;
  } ctrl_beat_t;

  typedef struct packed {
    addr_t addr;
    dtag_t tag;
  } lane_id_t;

  typedef struct packed {
    dbit_t dat;
    dbit_t derr;
  } lane_dec_t;

  function automatic logic [2 : 0] err_pop(input dbit_t f, input dbit_t b);
    return 3'(f[0]) + 3'(f[1]) + 3'(b[0]) + 3'(b[1]);
  endfunction

  // ----------------------------------------
  // control pipe
  // ----------------------------------------

  ctrl_beat_t ctrl_in, ctrl_out;
  lane_id_t   f_id_out, b_id_out;
  logic       rp_sop, rp_eop;  // framing aligned to bmc output

  assign ctrl_in = '{val: ival, ctrl: '{sop: isop, eop: ieop, last: ilast}};

  rsc2_delay_line #(.payload_t(ctrl_beat_t), .DEPTH(`RSC2_ENGINE_DELAY), .RESET_EN(1'b1))
  ctrl_line (.iclk(iclk), .ireset(ireset), .idata(ctrl_in), .odata(ctrl_out));

  rsc2_delay_line #(.payload_t(lane_id_t), .DEPTH(`RSC2_ENGINE_DELAY))
  f_id_line (.iclk(iclk), .ireset(ireset), .idata({ifaddr, ifs_tag}), .odata(f_id_out));

  rsc2_delay_line #(.payload_t(lane_id_t), .DEPTH(`RSC2_ENGINE_DELAY))
  b_id_line (.iclk(iclk), .ireset(ireset), .idata({ibaddr, ibs_tag}), .odata(b_id_out));

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rp_sop <= 1'b0;
      rp_eop <= 1'b0;
    end
    else begin
      rp_sop <= isop;
      rp_eop <= ieop;
    end
  end

  // ----------------------------------------
  // lanes
  // ----------------------------------------

  logic      f_bmc_val, b_bmc_val;
  dbit_t     f_bmc_dat, f_bmc_derr, b_bmc_dat, b_bmc_derr;
  state_t    f_bmc_metric, b_bmc_metric;
  lane_dec_t f_dec_out, b_dec_out;

  // odd passes swap, backward uses the inverse rule
  rsc2_dec_bmc f_bmc (
    .iclk(iclk), .ireset(ireset), .ival(ival), .ifirst(ifirst),
    .iswap(!ieven && ibitswap), .is_llr(ifs_llr), .ilextr(if_lextr),
    .oval(f_bmc_val), .odat(f_bmc_dat), .oderr(f_bmc_derr), .ometric(f_bmc_metric));

  rsc2_dec_bmc b_bmc (
    .iclk(iclk), .ireset(ireset), .ival(ival), .ifirst(ifirst),
    .iswap(!ieven && !ibitswap), .is_llr(ibs_llr), .ilextr(ib_lextr),
    .oval(b_bmc_val), .odat(b_bmc_dat), .oderr(b_bmc_derr), .ometric(b_bmc_metric));

  rsc2_dec_state_rp f_rp (
    .iclk(iclk), .ireset(ireset), .ival(f_bmc_val), .isop(rp_sop), .ieop(rp_eop),
    .ifirst(ifirst), .ieven(ieven), .imetric(f_bmc_metric),
    .istate_even(if_state_even), .istate_odd(if_state_odd), .oval(),
    .ostate(), .ostate_even(of_state_even), .ostate_odd(of_state_odd));

  rsc2_dec_state_rp b_rp (
    .iclk(iclk), .ireset(ireset), .ival(b_bmc_val), .isop(rp_sop), .ieop(rp_eop),
    .ifirst(ifirst), .ieven(ieven), .imetric(b_bmc_metric),
    .istate_even(ib_state_even), .istate_odd(ib_state_odd), .oval(),
    .ostate(), .ostate_even(ob_state_even), .ostate_odd(ob_state_odd));

  // decisions wait out the recursion stage
  rsc2_delay_line #(.payload_t(lane_dec_t), .DEPTH(`RSC2_RP_DELAY))
  f_dec_line (.iclk(iclk), .ireset(ireset), .idata({f_bmc_dat, f_bmc_derr}), .odata(f_dec_out));

  rsc2_delay_line #(.payload_t(lane_dec_t), .DEPTH(`RSC2_RP_DELAY))
  b_dec_line (.iclk(iclk), .ireset(ireset), .idata({b_bmc_dat, b_bmc_derr}), .odata(b_dec_out));

  // ----------------------------------------
  // output beat, error count, done
  // ----------------------------------------

  assign oval   = ctrl_out.val;
  assign osop   = ctrl_out.ctrl.sop;
  assign oeop   = ctrl_out.ctrl.eop;
  assign ofaddr = f_id_out.addr;
  assign ofdtag = f_id_out.tag;
  assign obaddr = b_id_out.addr;
  assign obdtag = b_id_out.tag;
  assign ofdat  = f_dec_out.dat;
  assign ofderr = f_dec_out.derr;
  assign obdat  = b_dec_out.dat;
  assign obderr = b_dec_out.derr;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oerr  <= '0;
      odone <= 1'b0;
    end
    else begin
      if (oval) begin
        // sop beat counts too
        oerr <= (osop ? '0 : oerr) + err_cnt_t'(err_pop(ofderr, obderr));
      end
      odone <= oval && oeop && ctrl_out.ctrl.last;
    end
  end

endmodule

// File: sim/tb_rsc2_tasks.svh
// rsc2 engine testbench tasks
// lane reference model, typed compares and the directed tests

`ifndef TB_RSC2_TASKS_SVH
`define TB_RSC2_TASKS_SVH

localparam int STATE_MAX = (1 << `RSC2_STATE_W) - 1;

typedef struct {
  int    cyc;  // drive cycle
  logic  sop, eop;
  addr_t faddr, baddr;
  dtag_t ftag, btag;
  dbit_t fdat, fderr, bdat, bderr;
} exp_beat_t;

int err_mark;
int exp_fe, exp_fo, exp_be, exp_bo;  // expected stored states

// ----------------------------------------
// reference model
// ----------------------------------------

function automatic int clip_llr(input int v);
  return (v > `RSC2_LLR_MAX) ? `RSC2_LLR_MAX : ((v < -`RSC2_LLR_MAX) ? -`RSC2_LLR_MAX : v);
endfunction

function automatic int add_state(input int a, input int m);
  return (a + m > STATE_MAX) ? STATE_MAX : a + m;  // clips at all ones
endfunction

// decisions, error flags and metric of one lane beat
function automatic void model_lane(input llr_pair_t s, input llr_pair_t e, input logic first,
                                   input logic swap, output dbit_t dat, output dbit_t derr,
                                   output int metric);
  bit_llr_t ch;
  bit_llr_t ex;
  int       sum;
  metric = 0;
  for (int b = 0; b < 2; b++) begin
    ch      = s[b];
    ex      = e[b];
    sum     = clip_llr(int'(ch) + (first ? 0 : int'(ex)));  // no extrinsic on first pass
    dat[b]  = (sum < 0);
    derr[b] = dat[b] ^ (ch < 0);
    metric += (sum < 0) ? -sum : sum;
  end
  if (swap) begin
    dat  = {dat[0], dat[1]};
    derr = {derr[0], derr[1]};
  end
endfunction

// ----------------------------------------
// compares and bookkeeping
// ----------------------------------------

task automatic report_value(input string what, input int exp, input int act);
  errors++;
  $display("FAIL %s: %s expected %0d actual %0d", cur_test, what, exp, act);
endtask

task automatic cmp_flag(input string what, input logic exp, input logic act);
  if (act !== exp) begin
    report_value(what, int'(exp), int'(act));
  end
endtask

task automatic cmp_dbit(input string what, input dbit_t exp, input dbit_t act);
  if (act !== exp) begin
    report_value(what, int'(exp), int'(act));
  end
endtask

task automatic cmp_state(input string what, input state_t exp, input state_t act);
  if (act !== exp) begin
    report_value(what, int'(exp), int'(act));
  end
endtask

task automatic cmp_err(input string what, input err_cnt_t exp, input err_cnt_t act);
  if (act !== exp) begin
    report_value(what, int'(exp), int'(act));
  end
endtask

task automatic cmp_addr(input string what, input addr_t exp, input addr_t act);
  if (act !== exp) begin
    report_value(what, int'(exp), int'(act));
  end
endtask

task automatic cmp_tag(input string what, input dtag_t exp, input dtag_t act);
  if (act !== exp) begin
    report_value(what, int'(exp), int'(act));
  end
endtask

task automatic check_states();
  cmp_state("of_state_even", state_t'(exp_fe), of_state_even);
  cmp_state("of_state_odd", state_t'(exp_fo), of_state_odd);
  cmp_state("ob_state_even", state_t'(exp_be), ob_state_even);
  cmp_state("ob_state_odd", state_t'(exp_bo), ob_state_odd);
endtask

task automatic start_test(input string name);
  cur_test = name;
  err_mark = errors;
endtask

task automatic end_test();
  tests_run++;
  if (errors == err_mark) begin
    $display("test %s ok", cur_test);
  end
  else begin
    tests_bad++;
    $display("test %s %0d errors", cur_test, errors - err_mark);
  end
endtask

// ----------------------------------------
// block driver and checker
// ----------------------------------------

// drives one block back to back, checks each output beat, then oerr and odone
task automatic run_block(input int nbeats, input logic first, input logic last,
                         input logic even, input logic bswap, input logic sat_mix);
  exp_beat_t   q[$];
  exp_beat_t   e;
  logic [15:0] r;
  int          cyc, i, dones, done_cyc, exp_err, f_run, b_run, fm, bm;
  cyc      = 0;
  i        = 0;
  dones    = 0;
  done_cyc = 0;
  exp_err  = 0;
  f_run    = first ? 0 : (even ? int'(if_state_even) : int'(if_state_odd));
  b_run    = first ? 0 : (even ? int'(ib_state_even) : int'(ib_state_odd));
  ifirst   = first;
  ilast    = last;
  ieven    = even;
  ibitswap = bswap;
  // on each falling edge sample the output beat first, then drive the next one
  while ((cyc <= nbeats + 3 || q.size() != 0) && cyc < nbeats + 16) begin
    if (oval) begin
      if (q.size() == 0) begin
        errors++;
        $display("FAIL %s: output beat with no input beat in flight", cur_test);
      end
      else begin
        e = q.pop_front();
        if (cyc - e.cyc != 2) begin
          report_value("beat latency", 2, cyc - e.cyc);
        end
        cmp_flag("osop", e.sop, osop);
        cmp_flag("oeop", e.eop, oeop);
        cmp_addr("ofaddr", e.faddr, ofaddr);
        cmp_addr("obaddr", e.baddr, obaddr);
        cmp_tag("ofdtag", e.ftag, ofdtag);
        cmp_tag("obdtag", e.btag, obdtag);
        cmp_dbit("ofdat", e.fdat, ofdat);
        cmp_dbit("ofderr", e.fderr, ofderr);
        cmp_dbit("obdat", e.bdat, obdat);
        cmp_dbit("obderr", e.bderr, obderr);
        if (e.eop) begin
          check_states();  // stored on the eop output beat
        end
      end
    end
    if (odone) begin
      dones++;
      done_cyc = cyc;
    end
    if (i < nbeats) begin
      take_bits(5, r);
      ifs_llr[0] = r[4:0];
      take_bits(5, r);
      ifs_llr[1] = r[4:0];
      take_bits(5, r);
      if_lextr[0] = r[4:0];
      take_bits(5, r);
      if_lextr[1] = r[4:0];
      take_bits(10, r);
      ibs_llr = r[9:0];
      take_bits(10, r);
      ib_lextr = r[9:0];
      if (sat_mix && i % 4 == 1) begin
        ifs_llr  = {5'b10000, 5'b01111};  // -16 -16 and 15 15 clip in both halves
        if_lextr = {5'b10000, 5'b01111};
        ibs_llr  = ifs_llr;
        ib_lextr = if_lextr;
      end
      else if (sat_mix && i % 4 == 3) begin
        ifs_llr  = {5'b11100, 5'b00011};  // extrinsic flips both signs
        if_lextr = {5'b01111, 5'b10000};
        ibs_llr  = ifs_llr;
        ib_lextr = if_lextr;
      end
      ival    = 1'b1;
      isop    = (i == 0);
      ieop    = (i == nbeats - 1);
      ifaddr  = addr_t'(i);
      ibaddr  = addr_t'(nbeats - 1 - i);  // backward walks down
      ifs_tag = dtag_t'(8'h40 + i);
      ibs_tag = dtag_t'(8'hc0 - i);
      e.cyc   = cyc;
      e.sop   = isop;
      e.eop   = ieop;
      e.faddr = ifaddr;
      e.baddr = ibaddr;
      e.ftag  = ifs_tag;
      e.btag  = ibs_tag;
      model_lane(ifs_llr, if_lextr, first, !even && bswap, e.fdat, e.fderr, fm);
      model_lane(ibs_llr, ib_lextr, first, !even && !bswap, e.bdat, e.bderr, bm);
      f_run    = add_state(f_run, fm);
      b_run    = add_state(b_run, bm);
      exp_err += $countones(e.fderr) + $countones(e.bderr);
      q.push_back(e);
      if (ieop) begin
        if (first) begin
          exp_fe = 0;
          exp_fo = 0;
          exp_be = 0;
          exp_bo = 0;
        end
        if (even) begin
          exp_fe = f_run;
          exp_be = b_run;
        end
        else begin
          exp_fo = f_run;
          exp_bo = b_run;
        end
      end
      i++;
    end
    else begin
      ival = 1'b0;
      isop = 1'b0;
      ieop = 1'b0;
    end
    @(negedge iclk);
    cyc++;
  end
  if (q.size() != 0) begin
    errors++;
    $display("FAIL %s: %0d output beats never appeared", cur_test, q.size());
  end
  cmp_err("oerr", err_cnt_t'(exp_err), oerr);
  if (dones != (last ? 1 : 0)) begin
    report_value("odone pulses", last ? 1 : 0, dones);
  end
  else if (last && done_cyc != nbeats + 2) begin
    report_value("odone cycles after eop input", 3, done_cyc - (nbeats - 1));
  end
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------

task automatic test_reset();
  start_test("reset");
  if (oval !== 1'b0 || odone !== 1'b0) begin
    errors++;
    $display("FAIL %s: oval or odone not low after reset", cur_test);
  end
  cmp_flag("osop", 1'b0, osop);
  cmp_flag("oeop", 1'b0, oeop);
  cmp_err("oerr", '0, oerr);
  check_states();
  end_test();
endtask

task automatic test_first_block();
  start_test("first");
  if_state_even = 10'd77;  // ignored on a first pass
  ib_state_even = 10'd99;
  run_block(12, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
  end_test();
endtask

task automatic test_saturation();
  start_test("saturate");
  if_state_even = 10'd100;
  ib_state_even = 10'd200;
  run_block(16, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
  end_test();
endtask

task automatic test_bit_swap();
  start_test("bitswap");
  run_block(10, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);  // backward swaps
  run_block(10, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);  // forward swaps
  run_block(10, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);  // even pass swaps neither
  end_test();
endtask

task automatic test_circular();
  start_test("circular");
  if_state_even = 10'd5;
  ib_state_even = 10'd7;
  if_state_odd  = 10'd1010;  // forward clips early
  ib_state_odd  = 10'd300;
  run_block(9, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);  // odd slots only
  run_block(9, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);  // new decode clears odd
  end_test();
endtask

task automatic test_done();
  start_test("done");
  run_block(8, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
  run_block(8, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
  run_block(1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);  // sop and eop on one beat
  end_test();
endtask

`endif

// File: sim/tb_rsc2_engine.sv
// rsc2 engine testbench top
// clock, reset, DUT, lfsr stimulus source, watchdog and summary

`timescale 1ns/100ps

`include "rsc2_engine_cfg.svh"

module tb_rsc2_engine;

  import rsc2_engine_pkg::*;

  localparam int TOTAL_BEATS = 12 + 16 + 3 * 10 + 2 * 9 + 2 * 8 + 1;
  localparam int WATCHDOG_NS = (TOTAL_BEATS + 10 * 8 + 50) * 4;  // 10 blocks, drain, margin

  logic      iclk, ireset;
  logic      ifirst, ilast, ieven, ibitswap;  // held per block
  logic      ival, isop, ieop;
  addr_t     ifaddr, ibaddr, ofaddr, obaddr;
  dtag_t     ifs_tag, ibs_tag, ofdtag, obdtag;
  llr_pair_t ifs_llr, ibs_llr, if_lextr, ib_lextr;
  state_t    if_state_even, if_state_odd, ib_state_even, ib_state_odd;
  state_t    of_state_even, of_state_odd, ob_state_even, ob_state_odd;
  dbit_t     ofdat, ofderr, obdat, obderr;
  err_cnt_t  oerr;
  logic      oval, osop, oeop, odone;

  int          errors    = 0;  // failed checks
  int          tests_run = 0;
  int          tests_bad = 0;
  string       cur_test;
  logic [15:0] lfsr_q    = 16'd10;  // seed

  rsc2_dec_engine uut (.*);

  initial begin
    iclk = 1'b0;
    forever #2 iclk = ~iclk;  // 4 ns period
  end

  // ----------------------------------------
  // stimulus source
  // ----------------------------------------

  // 16 bit galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v      = {v[14:0], lfsr_q[0]};  // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  `include "tb_rsc2_tasks.svh"

  // ----------------------------------------
  // run
  // ----------------------------------------

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run is stuck");
    $display("tests failed");
    $finish;
  end

  initial begin
    ireset = 1'b1;
    {ifirst, ilast, ieven, ibitswap, ival, isop, ieop} = '0;
    {ifaddr, ibaddr, ifs_tag, ibs_tag} = '0;
    {ifs_llr, ibs_llr, if_lextr, ib_lextr} = '0;
    {if_state_even, if_state_odd, ib_state_even, ib_state_odd} = '0;
    repeat (2) @(negedge iclk);
    ireset = 1'b0;
    test_reset();
    test_first_block();
    test_saturation();
    test_bit_swap();
    test_circular();
    test_done();
    $display("tests run %0d, with errors %0d, check errors %0d", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end
    else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: rsc2_engine.f
+incdir+rtl
+incdir+sim
rtl/rsc2_engine_pkg.sv
rtl/rsc2_delay_line.sv
rtl/rsc2_dec_bmc.sv
rtl/rsc2_dec_state_rp.sv
rtl/rsc2_dec_engine.sv
sim/tb_rsc2_engine.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the rsc2 engine testbench with verilator, run it, scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rsc2_engine -f rsc2_engine.f \
  --Mdir obj_dir -o sim_rsc2

./obj_dir/sim_rsc2 | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation clean"
